//--- rtl/cr_pkg.sv
// Offsets are 4-byte spaced; unmapped offsets read as zero and writes to them are dropped
package cr_pkg;

    // --------------------
    // Register map
    // --------------------

    // Writable display registers
    localparam logic [31:0] cr_seg7_0     = 32'h0000_0000;
    localparam logic [31:0] cr_seg7_1     = 32'h0000_0004;
    localparam logic [31:0] cr_seg7_2     = 32'h0000_0008;
    localparam logic [31:0] cr_seg7_3     = 32'h0000_000c;
    localparam logic [31:0] cr_seg7_4     = 32'h0000_0010;
    localparam logic [31:0] cr_seg7_5     = 32'h0000_0014;
    localparam logic [31:0] cr_led        = 32'h0000_0018;

    // Read-only board inputs
    localparam logic [31:0] cr_button_0   = 32'h0000_001c;
    localparam logic [31:0] cr_button_1   = 32'h0000_0020;
    localparam logic [31:0] cr_switch     = 32'h0000_0024;
    localparam logic [31:0] cr_joystick_x = 32'h0000_0028;
    localparam logic [31:0] cr_joystick_y = 32'h0000_002c;

    // --------------------
    // Default parameters
    // --------------------

    // Queue depth, also the credits the core starts with
    localparam int cr_credits_def  = 4;
    // Cycles a button must stay stable
    localparam int cr_debounce_def = 16;

    // --------------------
    // Board structs
    // --------------------

    // What the board sees, 58 bits
    typedef struct packed {
        logic [7:0] seg7_0;
        logic [7:0] seg7_1;
        logic [7:0] seg7_2;
        logic [7:0] seg7_3;
        logic [7:0] seg7_4;
        logic [7:0] seg7_5;
        logic [9:0] led;
    } t_fpga_out;

    // Raw board inputs, 36 bits
    typedef struct packed {
        logic        button_0;
        logic        button_1;
        logic [9:0]  switch;
        logic [11:0] joystick_x;
        logic [11:0] joystick_y;
    } t_fpga_in;

    // --------------------
    // Core channel structs
    // --------------------

    // One core access, 65 bits
    typedef struct packed {
        logic        write;    // 1 = write, 0 = read
        logic [31:0] address;
        logic [31:0] data;
    } t_cr_req;

    // Read data back to the core
    typedef struct packed {
        logic [31:0] data;
    } t_cr_rsp;

endpackage

//--- rtl/cr_ctrl.sv
// Sender must respect credits; a request arriving with a full queue overwrites the head
`timescale 1ns/1ps

module cr_ctrl #(
    parameter int CREDITS = cr_pkg::cr_credits_def
) (
    input  logic            Clk,
    input  logic            rst_n,
    input  logic            req_valid,
    input  cr_pkg::t_cr_req req,
    output logic            credit_return,
    output logic            wr_en,
    output logic            rd_en,
    output logic [31:0]     address,
    output logic [31:0]     wdata
);
    import cr_pkg::*;

    // Pointer stays one bit wide for a single-entry queue
    localparam int PTR_W = (CREDITS > 1) ? $clog2(CREDITS) : 1;
    localparam int CNT_W = $clog2(CREDITS + 1);

    t_cr_req          queue_mem [CREDITS];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    t_cr_req          head;
    logic             wr_last;
    logic             pop;

    // Wrap at CREDITS, also for depths that are not a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(CREDITS - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // --------------------
    // Queue storage
    // --------------------

    // Every valid request lands here in its own cycle
    always_ff @(posedge Clk) begin
        if (req_valid) begin
            queue_mem[wr_ptr] <= req;
        end
    end

    assign head = queue_mem[rd_ptr];

    // --------------------
    // Issue
    // --------------------

    // Display regs reach the read mux one cycle after the write edge,
    // so a read right behind a write waits one cycle
    assign pop = (count != '0) && !(wr_last && !head.write);

    assign wr_en   = pop && head.write;
    assign rd_en   = pop && !head.write;
    assign address = head.address;
    assign wdata   = head.data;

    // --------------------
    // Pointers and fill
    // --------------------
    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
            wr_last       <= 1'b0;
        end else begin
            if (req_valid) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            // Push and pop together keep the fill
            case ({req_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // One credit back per issued access, a cycle later
            credit_return <= pop;
            wr_last       <= wr_en;
        end
    end

endmodule

//--- rtl/cr_in_sync.sv
// Inputs are treated as asynchronous; buttons lag by DEBOUNCE cycles after the two sync stages
`timescale 1ns/1ps

module cr_in_sync #(
    parameter int DEBOUNCE = cr_pkg::cr_debounce_def
) (
    input  logic             Clk,
    input  logic             rst_n,
    input  cr_pkg::t_fpga_in fpga_in,
    output cr_pkg::t_fpga_in fpga_in_sync
);
    import cr_pkg::*;

    localparam int CNT_W = $clog2(DEBOUNCE + 1);

    t_fpga_in         sync_1;
    t_fpga_in         sync_2;
    logic [1:0]       btn_raw;
    logic [1:0]       btn_db;
    logic [CNT_W-1:0] btn_cnt [2];

    // --------------------
    // Two-flop sync
    // --------------------

    // fpga_in -> sync_1 -> sync_2
    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            sync_1 <= '0;
            sync_2 <= '0;
        end else begin
            sync_1 <= fpga_in;
            sync_2 <= sync_1;
        end
    end

    // --------------------
    // Button debounce
    // --------------------

    // Bit 0 is button_0
    assign btn_raw = {sync_2.button_1, sync_2.button_0};

    // Count cycles of disagreement, any agreement restarts the count
    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            btn_db  <= '0;
            btn_cnt <= '{default: '0};
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (btn_raw[i] == btn_db[i]) begin
                    btn_cnt[i] <= '0;
                end else if (btn_cnt[i] == CNT_W'(DEBOUNCE - 1)) begin
                    // DEBOUNCE-th differing cycle, take the new level
                    btn_db[i]  <= btn_raw[i];
                    btn_cnt[i] <= '0;
                end else begin
                    btn_cnt[i] <= btn_cnt[i] + 1'b1;
                end
            end
        end
    end

    // Switch and joystick straight from sync_2, buttons from debouncer
    always_comb begin
        fpga_in_sync          = sync_2;
        fpga_in_sync.button_0 = btn_db[0];
        fpga_in_sync.button_1 = btn_db[1];
    end

endmodule

//--- rtl/cr_out_regs.sv
// Write data is truncated to the field width; fpga_out trails the register state by one cycle
`timescale 1ns/1ps

module cr_out_regs (
    input  logic              Clk,
    input  logic              rst_n,
    input  logic              wr_en,
    input  logic [31:0]       address,
    input  logic [31:0]       wdata,
    output cr_pkg::t_fpga_out fpga_out
);
    import cr_pkg::*;

    // state_next -> state_q -> fpga_out
    t_fpga_out state_next;
    t_fpga_out state_q;

    // --------------------
    // Write decode
    // --------------------
    always_comb begin
        state_next = state_q;
        if (wr_en) begin
            unique case (address)
                // Seven-segment bytes, low 8 bits
                cr_seg7_0: state_next.seg7_0 = wdata[7:0];
                cr_seg7_1: state_next.seg7_1 = wdata[7:0];
                cr_seg7_2: state_next.seg7_2 = wdata[7:0];
                cr_seg7_3: state_next.seg7_3 = wdata[7:0];
                cr_seg7_4: state_next.seg7_4 = wdata[7:0];
                cr_seg7_5: state_next.seg7_5 = wdata[7:0];
                // LEDs, low 10 bits
                cr_led:    state_next.led    = wdata[9:0];
                // Read-only and unmapped, hold
                default: ;
            endcase
        end
    end

    // --------------------
    // Output pipeline
    // --------------------

    // Stage 1 is the register state, stage 2 drives the board
    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            state_q  <= '0;
            fpga_out <= '0;
        end else begin
            state_q  <= state_next;
            fpga_out <= state_q;
        end
    end

endmodule

//--- rtl/cr_read_mux.sv
// Display fields are read from the board-facing stage; unmapped offsets return zero
`timescale 1ns/1ps

module cr_read_mux (
    input  logic              Clk,
    input  logic              rst_n,
    input  logic              rd_en,
    input  logic [31:0]       address,
    input  logic [31:0]       address_b,
    input  cr_pkg::t_fpga_out fpga_out,
    input  cr_pkg::t_fpga_in  fpga_in_sync,
    output logic              rsp_valid,
    output cr_pkg::t_cr_rsp   rsp,
    output logic [31:0]       q_b
);
    import cr_pkg::*;

    logic [31:0] core_data;
    logic [31:0] fabric_data;

    // Shared register-map decode, fields zero-extended to 32 bits
    function automatic logic [31:0] reg_decode(input logic [31:0] addr,
                                               input t_fpga_out   disp,
                                               input t_fpga_in    board);
        unique case (addr)
            // Display registers
            cr_seg7_0:     return {24'b0, disp.seg7_0};
            cr_seg7_1:     return {24'b0, disp.seg7_1};
            cr_seg7_2:     return {24'b0, disp.seg7_2};
            cr_seg7_3:     return {24'b0, disp.seg7_3};
            cr_seg7_4:     return {24'b0, disp.seg7_4};
            cr_seg7_5:     return {24'b0, disp.seg7_5};
            cr_led:        return {22'b0, disp.led};
            // Board inputs
            cr_button_0:   return {31'b0, board.button_0};
            cr_button_1:   return {31'b0, board.button_1};
            cr_switch:     return {22'b0, board.switch};
            cr_joystick_x: return {20'b0, board.joystick_x};
            cr_joystick_y: return {20'b0, board.joystick_y};
            default:       return 32'b0;
        endcase
    endfunction

    assign core_data   = reg_decode(address, fpga_out, fpga_in_sync);
    assign fabric_data = reg_decode(address_b, fpga_out, fpga_in_sync);

    // --------------------
    // Core port
    // --------------------

    // Response one cycle after issue
    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= rd_en;
        end
    end

    // Data only loads on a read
    always_ff @(posedge Clk) begin
        if (rd_en) begin
            rsp.data <= core_data;
        end
    end

    // --------------------
    // Fabric port
    // --------------------

    // Free-running, no strobe
    always_ff @(posedge Clk) begin
        q_b <= fabric_data;
    end

endmodule

//--- rtl/cr_mem_top.sv
// Core side is credit based with no response stall; fabric side is read-only
`timescale 1ns/1ps

module cr_mem_top #(
    parameter int CREDITS  = cr_pkg::cr_credits_def,
    parameter int DEBOUNCE = cr_pkg::cr_debounce_def
) (
    input  logic              Clk,
    input  logic              rst_n,
    // Core request and response
    input  logic              req_valid,
    input  cr_pkg::t_cr_req   req,
    output logic              credit_return,
    output logic              rsp_valid,
    output cr_pkg::t_cr_rsp   rsp,
    // Board and fabric
    input  cr_pkg::t_fpga_in  fpga_in,
    input  logic [31:0]       address_b,
    output logic [31:0]       q_b,
    output cr_pkg::t_fpga_out fpga_out
);
    import cr_pkg::*;

    // Issued access from the queue
    logic        wr_en;
    logic        rd_en;
    logic [31:0] address;
    logic [31:0] wdata;
    // Synchronized board inputs
    t_fpga_in    fpga_in_sync;

    // --------------------
    // Request queue
    // --------------------
    cr_ctrl #(
        .CREDITS (CREDITS)
    ) cr_ctrl_i (
        .Clk           (Clk),
        .rst_n         (rst_n),
        .req_valid     (req_valid),
        .req           (req),
        .credit_return (credit_return),
        .wr_en         (wr_en),
        .rd_en         (rd_en),
        .address       (address),
        .wdata         (wdata)
    );

    // --------------------
    // Board inputs
    // --------------------
    cr_in_sync #(
        .DEBOUNCE (DEBOUNCE)
    ) cr_in_sync_i (
        .Clk          (Clk),
        .rst_n        (rst_n),
        .fpga_in      (fpga_in),
        .fpga_in_sync (fpga_in_sync)
    );

    // Display registers, last stage shared by board and read mux
    cr_out_regs cr_out_regs_i (
        .Clk      (Clk),
        .rst_n    (rst_n),
        .wr_en    (wr_en),
        .address  (address),
        .wdata    (wdata),
        .fpga_out (fpga_out)
    );

    // Both read ports
    cr_read_mux cr_read_mux_i (
        .Clk          (Clk),
        .rst_n        (rst_n),
        .rd_en        (rd_en),
        .address      (address),
        .address_b    (address_b),
        .fpga_out     (fpga_out),
        .fpga_in_sync (fpga_in_sync),
        .rsp_valid    (rsp_valid),
        .rsp          (rsp),
        .q_b          (q_b)
    );

endmodule

//--- sim/cr_mem_tb.sv
// Directed tests for cr_mem_top with CREDITS 4 and DEBOUNCE 16; inputs change on the falling edge
`timescale 1ns/1ps

module cr_mem_tb;
    import cr_pkg::*;

    localparam int CREDITS    = 4;
    localparam int DEBOUNCE   = 16;
    localparam int CLK_PERIOD = 8;
    localparam int NUM_TESTS  = 6;
    // Debounce test is the longest, about 200 cycles
    localparam int MAX_CYCLES = 500;

    logic        clk;
    logic        rst_n;
    logic        req_valid;
    t_cr_req     req;
    logic        credit_return;
    logic        rsp_valid;
    t_cr_rsp     rsp;
    t_fpga_in    fpga_in;
    logic [31:0] address_b;
    logic [31:0] q_b;
    t_fpga_out   fpga_out;

    // Scoreboard and reference model
    int          credits = CREDITS;
    int          min_credits = CREDITS;
    int          errors = 0;
    int          checks = 0;
    int          rsp_count = 0;
    logic [31:0] exp_q [$];
    t_fpga_out   model_out = '0;
    t_fpga_in    model_in = '0;
    logic [1:0]  model_btn = '0;
    logic [31:0] mapped_addr [12] = '{cr_seg7_0, cr_seg7_1, cr_seg7_2, cr_seg7_3, cr_seg7_4,
        cr_seg7_5, cr_led, cr_button_0, cr_button_1, cr_switch, cr_joystick_x, cr_joystick_y};
    logic [31:0] unmapped_addr [5] = '{32'h30, 32'h34, 32'h2, 32'h1000, 32'hffff_fffc};

    cr_mem_top #(
        .CREDITS  (CREDITS),
        .DEBOUNCE (DEBOUNCE)
    ) cr_mem_top_i (
        .Clk           (clk),
        .rst_n         (rst_n),
        .req_valid     (req_valid),
        .req           (req),
        .credit_return (credit_return),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .fpga_in       (fpga_in),
        .address_b     (address_b),
        .q_b           (q_b),
        .fpga_out      (fpga_out)
    );

    // --------------------
    // Reference model
    // --------------------

    // Register map as seen by a reader, fields zero-extended
    function automatic logic [31:0] expected_read(input logic [31:0] addr);
        case (addr)
            cr_seg7_0:     return {24'h0, model_out.seg7_0};
            cr_seg7_1:     return {24'h0, model_out.seg7_1};
            cr_seg7_2:     return {24'h0, model_out.seg7_2};
            cr_seg7_3:     return {24'h0, model_out.seg7_3};
            cr_seg7_4:     return {24'h0, model_out.seg7_4};
            cr_seg7_5:     return {24'h0, model_out.seg7_5};
            cr_led:        return {22'h0, model_out.led};
            cr_button_0:   return {31'h0, model_btn[0]};
            cr_button_1:   return {31'h0, model_btn[1]};
            cr_switch:     return {22'h0, model_in.switch};
            cr_joystick_x: return {20'h0, model_in.joystick_x};
            cr_joystick_y: return {20'h0, model_in.joystick_y};
            default:       return 32'h0;
        endcase
    endfunction

    // Writable fields keep only their low bits
    function automatic void apply_write(input logic [31:0] addr, input logic [31:0] data);
        case (addr)
            cr_seg7_0: model_out.seg7_0 = data[7:0];
            cr_seg7_1: model_out.seg7_1 = data[7:0];
            cr_seg7_2: model_out.seg7_2 = data[7:0];
            cr_seg7_3: model_out.seg7_3 = data[7:0];
            cr_seg7_4: model_out.seg7_4 = data[7:0];
            cr_seg7_5: model_out.seg7_5 = data[7:0];
            cr_led:    model_out.led    = data[9:0];
            default: ;
        endcase
    endfunction

    // --------------------
    // Helpers
    // --------------------

    // One cycle, credits collected at the falling edge
    task automatic tick();
        @(negedge clk);
        if (credit_return) begin
            credits++;
            assert (credits <= CREDITS) else begin
                $display("Credit returned with no request outstanding");
                errors++;
            end
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("CHECK FAILED: %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // Waits for a credit, then sends one request in this cycle
    task automatic send_request(input logic write, input logic [31:0] addr,
                                input logic [31:0] data);
        while (credits == 0) begin
            tick();
        end
        req_valid   = 1'b1;
        req.write   = write;
        req.address = addr;
        req.data    = data;
        credits--;
        min_credits = (credits < min_credits) ? credits : min_credits;
        if (write) begin
            apply_write(addr, data);
        end else begin
            exp_q.push_back(expected_read(addr));
        end
        tick();
        req_valid = 1'b0;
    endtask

    // All credits home, then two cycles for the output pipeline
    task automatic drain();
        while (credits != CREDITS) begin
            tick();
        end
        tick();
        tick();
    endtask

    // q_b holds the decode one cycle after address_b
    task automatic fabric_read(input logic [31:0] addr);
        address_b = addr;
        tick();
        check_value("q_b", 64'(q_b), 64'(expected_read(addr)));
    endtask

    task automatic set_button(input int idx, input logic val);
        if (idx == 0) begin
            model_in.button_0 = val;
        end else begin
            model_in.button_1 = val;
        end
        fpga_in = model_in;
    endtask

    task automatic report_test(input string name, input int err_start);
        if (exp_q.size() != 0) begin
            $display("%0d reads in %s never got a response", exp_q.size(), name);
            errors++;
            exp_q.delete();
        end
        if (errors == err_start) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d failures", name, errors - err_start);
        end
    endtask

    // --------------------
    // Tests
    // --------------------
    task automatic test_reset_state();
        int err_start;
        err_start = errors;
        check_value("fpga_out", 64'(fpga_out), 64'h0);
        check_value("credit_return", 64'(credit_return), 64'h0);
        check_value("rsp_valid", 64'(rsp_valid), 64'h0);
        foreach (mapped_addr[i]) begin
            send_request(1'b0, mapped_addr[i], 32'h0);
        end
        drain();
        report_test("reset_state", err_start);
    endtask

    task automatic test_write_read();
        int err_start;
        err_start = errors;
        for (int i = 0; i < 7; i++) begin
            send_request(1'b1, mapped_addr[i], $urandom);
        end
        drain();
        check_value("fpga_out", 64'(fpga_out), 64'(model_out));
        for (int i = 0; i < 7; i++) begin
            send_request(1'b0, mapped_addr[i], 32'h0);
        end
        drain();
        report_test("write_read", err_start);
    endtask

    task automatic test_credit_backpressure();
        int          err_start;
        int          rsp_start;
        logic [31:0] addr;
        err_start   = errors;
        rsp_start   = rsp_count;
        min_credits = credits;
        // Each read-back stalls a cycle behind its write
        // Queue then fills faster than it drains
        for (int i = 0; i < 10; i++) begin
            addr = mapped_addr[$urandom % 7];
            send_request(1'b1, addr, $urandom);
            send_request(1'b0, addr, 32'h0);
        end
        drain();
        check_value("rsp_count", 64'(rsp_count - rsp_start), 64'd10);
        check_value("credits", 64'(credits), 64'(CREDITS));
        if (min_credits != 0) begin
            $display("Credits were never exhausted during back-to-back requests");
            errors++;
        end
        report_test("credit_backpressure", err_start);
    endtask

    task automatic test_input_sync();
        int err_start;
        err_start = errors;
        for (int round = 0; round < 3; round++) begin
            model_in.switch     = 10'($urandom);
            model_in.joystick_x = 12'($urandom);
            model_in.joystick_y = 12'($urandom);
            fpga_in = model_in;
            // Two sync flops plus the read register
            repeat (3) tick();
            for (int i = 9; i < 12; i++) begin
                fabric_read(mapped_addr[i]);
                send_request(1'b0, mapped_addr[i], 32'h0);
            end
            drain();
        end
        report_test("input_sync", err_start);
    endtask

    task automatic test_button_debounce();
        int err_start;
        int len;
        err_start = errors;
        for (int b = 0; b < 2; b++) begin
            // Glitch of 1 to DEBOUNCE-1 cycles must stay invisible
            len = 1 + ($urandom % (DEBOUNCE - 1));
            fabric_read(mapped_addr[7 + b]);
            set_button(b, 1'b1);
            repeat (len) fabric_read(mapped_addr[7 + b]);
            set_button(b, 1'b0);
            repeat (DEBOUNCE + 6) fabric_read(mapped_addr[7 + b]);
            // Held level, accepted after sync plus DEBOUNCE
            set_button(b, 1'b1);
            repeat (DEBOUNCE + 4) tick();
            model_btn[b] = 1'b1;
            fabric_read(mapped_addr[7 + b]);
            send_request(1'b0, mapped_addr[7 + b], 32'h0);
            drain();
            set_button(b, 1'b0);
            repeat (DEBOUNCE + 4) tick();
            model_btn[b] = 1'b0;
            fabric_read(mapped_addr[7 + b]);
            send_request(1'b0, mapped_addr[7 + b], 32'h0);
            drain();
        end
        report_test("button_debounce", err_start);
    endtask

    task automatic test_unmapped();
        int err_start;
        err_start = errors;
        foreach (unmapped_addr[i]) begin
            send_request(1'b1, unmapped_addr[i], $urandom);
        end
        drain();
        check_value("fpga_out", 64'(fpga_out), 64'(model_out));
        foreach (unmapped_addr[i]) begin
            fabric_read(unmapped_addr[i]);
            send_request(1'b0, unmapped_addr[i], 32'h0);
        end
        foreach (mapped_addr[i]) begin
            send_request(1'b0, mapped_addr[i], 32'h0);
        end
        drain();
        report_test("unmapped", err_start);
    endtask

    // --------------------
    // Clock, watchdog, response checker
    // --------------------
    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(NUM_TESTS * MAX_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish in %0d ns",
                 NUM_TESTS * MAX_CYCLES * CLK_PERIOD);
        $display("ERRORS FOUND");
        $finish;
    end

    // Responses in request order against the expected queue
    initial begin
        logic [31:0] exp_data;
        forever begin
            @(negedge clk);
            if (rsp_valid) begin
                rsp_count++;
                if (exp_q.size() == 0) begin
                    $display("Response arrived with no read outstanding");
                    errors++;
                end else begin
                    exp_data = exp_q.pop_front();
                    check_value("rsp.data", 64'(rsp.data), 64'(exp_data));
                end
            end
        end
    end

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        void'($urandom(32'hf8e5));
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        fpga_in   = '0;
        address_b = '0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        tick();
        test_reset_state();
        test_write_read();
        test_credit_backpressure();
        test_input_sync();
        test_button_debounce();
        test_unmapped();
        $display("Summary: %0d tests, %0d checks, %0d failures", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- compile.f
rtl/cr_pkg.sv
rtl/cr_ctrl.sv
rtl/cr_in_sync.sv
rtl/cr_out_regs.sv
rtl/cr_read_mux.sv
rtl/cr_mem_top.sv
sim/cr_mem_tb.sv

//--- Bender.yml
package:
  name: cr_mem

sources:
  - files:
      - rtl/cr_pkg.sv
      - rtl/cr_ctrl.sv
      - rtl/cr_in_sync.sv
      - rtl/cr_out_regs.sv
      - rtl/cr_read_mux.sv
      - rtl/cr_mem_top.sv
  - target: simulation
    files:
      - sim/cr_mem_tb.sv
